// File: logic/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

`define EE_ADDR_W       11
`define EE_DATA_W       8
`define EE_QUARTER      4
`define EE_DEVICE_CODE  4'b1010

`endif

// File: logic/eeprom_pkg.sv
package eeprom_pkg;

    // one bus unit as run by the timer and shifter
    typedef enum logic [1:0] {
        UNIT_START,
        UNIT_BYTE_OUT,
        UNIT_BYTE_IN,
        UNIT_STOP
    } unit_kind_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA_W,
        ST_RESTART,   // repeated start of a random read
        ST_CTRL_R,
        ST_DATA_R,
        ST_STOP,
        ST_DONE
    } seq_state_t;

endpackage

// File: logic/eeprom_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  unit_done,
    input  logic [`EE_DATA_W-1:0] rx_byte,
    output logic                  start_unit,
    output unit_kind_t            unit_kind,
    output logic                  load,
    output logic [`EE_DATA_W-1:0] load_byte,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  done,
    output logic                  busy
);
    seq_state_t            state;
    seq_state_t            next_state;
    unit_kind_t            next_kind;
    logic                  step;
    logic                  accept;
    logic                  op_read;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;

    assign step   = (next_state != state);
    assign accept = (state == ST_IDLE) && (wr || rd);

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (wr || rd)
                    next_state = ST_START;
            ST_START:
                if (unit_done)
                    next_state = ST_CTRL_W;
            ST_CTRL_W:
                if (unit_done)
                    next_state = ST_ADDR;
            ST_ADDR:
                if (unit_done)
                    next_state = op_read ? ST_RESTART : ST_DATA_W;
            ST_DATA_W:
                if (unit_done)
                    next_state = ST_STOP;
            ST_RESTART:
                if (unit_done)
                    next_state = ST_CTRL_R;
            ST_CTRL_R:
                if (unit_done)
                    next_state = ST_DATA_R;
            ST_DATA_R:
                if (unit_done)
                    next_state = ST_STOP;
            ST_STOP:
                if (unit_done)
                    next_state = ST_DONE;
            ST_DONE:
                next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_comb
    begin
        case (next_state)
            ST_CTRL_W, ST_ADDR, ST_DATA_W, ST_CTRL_R:
                next_kind = UNIT_BYTE_OUT;
            ST_DATA_R:
                next_kind = UNIT_BYTE_IN;
            ST_STOP:
                next_kind = UNIT_STOP;
            default:
                next_kind = UNIT_START;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= ST_IDLE;
            start_unit <= 1'b0;
            unit_kind  <= UNIT_START;
            load       <= 1'b0;
            done       <= 1'b0;
            busy       <= 1'b0;
        end
        else
        begin
            state      <= next_state;
            // next unit begins right after the previous one ends
            start_unit <= step && next_state != ST_IDLE && next_state != ST_DONE;
            load       <= step && next_kind == UNIT_BYTE_OUT && next_state != ST_IDLE
                          && next_state != ST_DONE;
            done       <= step && next_state == ST_DONE;
            if (step)
                unit_kind <= next_kind;

            if (accept)
                busy <= 1'b1;
            else if (state == ST_DONE)
                busy <= 1'b0;   // falls with done
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_read <= !wr;   // write wins when both are high
            addr_q  <= addr;
            wdata_q <= wdata;
        end

        if (step)
        begin
            case (next_state)
                ST_CTRL_W:
                    load_byte <= {`EE_DEVICE_CODE, addr_q[`EE_ADDR_W-1:8], 1'b0};
                ST_CTRL_R:
                    load_byte <= {`EE_DEVICE_CODE, addr_q[`EE_ADDR_W-1:8], 1'b1};
                ST_ADDR:
                    load_byte <= addr_q[7:0];
                ST_DATA_W:
                    load_byte <= wdata_q;
                default:
                    load_byte <= load_byte;
            endcase
        end

        if (state == ST_DATA_R && unit_done)
            rdata <= rx_byte;
    end

endmodule

// File: logic/scl_bit_timer.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module scl_bit_timer
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       start_unit,
    input  unit_kind_t unit_kind,
    output logic       scl,
    output logic       change_tick,
    output logic       sample_tick,
    output logic [3:0] bit_index,
    output logic       unit_done
);
    localparam int QW = $clog2(`EE_QUARTER);

    logic          active;
    logic [QW-1:0] q_cnt;
    logic [1:0]    phase;
    logic [3:0]    bit_cnt;
    logic          run;
    logic [QW-1:0] cur_q;
    logic [1:0]    cur_phase;
    logic          quarter_end;
    logic          last_period;

    // the start_unit cycle already counts as quarter 0
    assign run       = active | start_unit;
    assign cur_q     = start_unit ? '0 : q_cnt;
    assign cur_phase = start_unit ? 2'd0 : phase;
    assign bit_index = start_unit ? 4'd0 : bit_cnt;

    assign quarter_end = run && (cur_q == QW'(`EE_QUARTER - 1));
    assign last_period = (unit_kind == UNIT_START || unit_kind == UNIT_STOP) ?
                         1'b1 : (bit_index == 4'd8);

    assign change_tick = quarter_end && (cur_phase == 2'd0);   // middle of scl low
    assign sample_tick = quarter_end && (cur_phase == 2'd2);   // middle of scl high
    assign unit_done   = quarter_end && (cur_phase == 2'd3) && last_period;
    assign scl         = run ? cur_phase[1] : 1'b1;   // parked high between operations

    always_ff @(posedge CLK)
    begin
        if (RESET || unit_done)
        begin
            active  <= 1'b0;
            q_cnt   <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
        end
        else if (run)
        begin
            active <= 1'b1;
            if (quarter_end)
            begin
                q_cnt   <= '0;
                phase   <= cur_phase + 2'd1;   // wraps into next period
                bit_cnt <= (cur_phase == 2'd3) ? bit_index + 4'd1 : bit_index;
            end
            else
            begin
                q_cnt   <= cur_q + 1'b1;
                phase   <= cur_phase;
                bit_cnt <= bit_index;
            end
        end
    end

endmodule

// File: logic/sda_shifter.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module sda_shifter
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  load,
    input  logic [`EE_DATA_W-1:0] load_byte,
    input  unit_kind_t            unit_kind,
    input  logic                  change_tick,
    input  logic                  sample_tick,
    input  logic [3:0]            bit_index,
    input  logic                  sda_in,
    output logic                  sda_pull_low,
    output logic [`EE_DATA_W-1:0] rx_byte
);
    logic [`EE_DATA_W-1:0] tx_shift;
    logic                  data_bit;

    assign data_bit = (bit_index < 4'(`EE_DATA_W));   // low for the ninth bit

    always_ff @(posedge CLK)
    begin
        if (load)
            tx_shift <= load_byte;
        else if (change_tick && unit_kind == UNIT_BYTE_OUT && data_bit)
            tx_shift <= {tx_shift[`EE_DATA_W-2:0], 1'b0};

        // msb first
        if (sample_tick && unit_kind == UNIT_BYTE_IN && data_bit)
            rx_byte <= {rx_byte[`EE_DATA_W-2:0], sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            sda_pull_low <= 1'b0;
        else if (change_tick)
        begin
            case (unit_kind)
                UNIT_BYTE_OUT:
                    sda_pull_low <= data_bit && !tx_shift[`EE_DATA_W-1];
                UNIT_STOP:
                    sda_pull_low <= 1'b1;   // low before scl rises
                default:
                    sda_pull_low <= 1'b0;   // released so a read ends with a nack
            endcase
        end
        else if (sample_tick)
        begin
            if (unit_kind == UNIT_START)
                sda_pull_low <= 1'b1;   // falling sda with scl high
            else if (unit_kind == UNIT_STOP)
                sda_pull_low <= 1'b0;   // rising sda with scl high
        end
    end

endmodule

// File: logic/eeprom_master.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_master
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  done,
    output logic                  busy,
    output logic                  scl,
    output logic                  sda_pull_low,
    input  logic                  sda_in
);
    logic                  start_unit;
    unit_kind_t            unit_kind;
    logic                  unit_done;
    logic                  change_tick;
    logic                  sample_tick;
    logic [3:0]            bit_index;
    logic                  load;
    logic [`EE_DATA_W-1:0] load_byte;
    logic [`EE_DATA_W-1:0] rx_byte;

    eeprom_sequencer i_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .unit_done  (unit_done),
        .rx_byte    (rx_byte),
        .start_unit (start_unit),
        .unit_kind  (unit_kind),
        .load       (load),
        .load_byte  (load_byte),
        .rdata      (rdata),
        .done       (done),
        .busy       (busy)
    );

    scl_bit_timer i_timer (
        .CLK         (CLK),
        .RESET       (RESET),
        .start_unit  (start_unit),
        .unit_kind   (unit_kind),
        .scl         (scl),
        .change_tick (change_tick),
        .sample_tick (sample_tick),
        .bit_index   (bit_index),
        .unit_done   (unit_done)
    );

    sda_shifter i_shifter (
        .CLK          (CLK),
        .RESET        (RESET),
        .load         (load),
        .load_byte    (load_byte),
        .unit_kind    (unit_kind),
        .change_tick  (change_tick),
        .sample_tick  (sample_tick),
        .bit_index    (bit_index),
        .sda_in       (sda_in),
        .sda_pull_low (sda_pull_low),
        .rx_byte      (rx_byte)
    );

endmodule

// File: sim/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    output logic sda_pull_low
);
    logic [7:0]  mem [0:(1 << `EE_ADDR_W) - 1];
    logic        scl_q;
    logic        sda_q;
    logic [3:0]  cnt;            // 15 while waiting for the first scl fall
    logic [1:0]  idx;
    logic [7:0]  shift;
    logic [7:0]  tx;
    logic [2:0]  blk;
    logic [10:0] ptr;
    logic        read_pending;
    logic        sending;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = 8'hff;
        scl_q        = 1'b1;
        sda_q        = 1'b1;
        cnt          = 4'd15;
        idx          = 2'd0;
        shift        = 8'h00;
        tx           = 8'h00;
        blk          = 3'd0;
        ptr          = '0;
        read_pending = 1'b0;
        sending      = 1'b0;
        sda_pull_low = 1'b0;
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl_q && scl && sda_q && !sda)
        begin
            // start or repeated start
            cnt          <= 4'd15;
            idx          <= 2'd0;
            read_pending <= 1'b0;
            sending      <= 1'b0;
            sda_pull_low <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            cnt          <= 4'd15;   // stop
            sda_pull_low <= 1'b0;
        end
        else if (!scl_q && scl && cnt < 4'd8)
            shift <= {shift[6:0], sda};
        else if (scl_q && !scl)
        begin
            if (cnt == 4'd15)
                cnt <= 4'd0;
            else if (cnt == 4'd8)
            begin
                cnt <= 4'd0;
                if (read_pending)
                begin
                    read_pending <= 1'b0;
                    sending      <= 1'b1;
                    tx           <= mem[ptr];
                    sda_pull_low <= !mem[ptr][7];
                end
                else
                    sda_pull_low <= 1'b0;
            end
            else if (cnt == 4'd7)
            begin
                cnt <= 4'd8;
                if (sending)
                begin
                    sending      <= 1'b0;
                    sda_pull_low <= 1'b0;   // master answers with nack
                end
                else
                begin
                    idx <= idx + 2'd1;
                    case (idx)
                        2'd0:
                        begin
                            sda_pull_low <= (shift[7:4] == `EE_DEVICE_CODE);
                            blk          <= shift[3:1];
                            if (shift[0])
                            begin
                                read_pending <= 1'b1;
                                ptr          <= {shift[3:1], ptr[7:0]};
                            end
                        end
                        2'd1:
                        begin
                            ptr          <= {blk, shift};
                            sda_pull_low <= 1'b1;
                        end
                        default:
                        begin
                            mem[ptr]     <= shift;
                            sda_pull_low <= 1'b1;
                        end
                    endcase
                end
            end
            else
            begin
                cnt <= cnt + 4'd1;
                if (sending)
                    sda_pull_low <= !tx[3'd6 - cnt[2:0]];
            end
        end
    end

endmodule

// File: sim/eeprom_properties.sv
`timescale 1ns/1ps

module eeprom_properties
    import eeprom_pkg::*;
(
    input logic       CLK,
    input logic       RESET,
    input logic       scl,
    input logic       sda_pull_low,
    input logic       done,
    input logic       busy,
    input unit_kind_t unit_kind
);
    // sda edges with scl high belong to start and stop only
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_pull_low != $past(sda_pull_low))
        |-> (unit_kind == UNIT_START || unit_kind == UNIT_STOP))
    else $error("sda changed while scl high outside start or stop");

    assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
    else $error("done lasted more than one cycle");

    assert property (@(posedge CLK) disable iff (RESET) done |=> !busy)
    else $error("busy still high after done");

endmodule

bind eeprom_master eeprom_properties i_props (
    .CLK          (CLK),
    .RESET        (RESET),
    .scl          (scl),
    .sda_pull_low (sda_pull_low),
    .done         (done),
    .busy         (busy),
    .unit_kind    (unit_kind)
);

// File: sim/eeprom_master_tb.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_master_tb;
    logic                  CLK = 1'b0;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  done;
    logic                  busy;
    logic                  scl;
    logic                  dut_pull;
    logic                  model_pull;
    logic                  sda_line;

    byte                   op_q [$];
    logic [`EE_ADDR_W-1:0] addr_q [$];
    logic [`EE_DATA_W-1:0] data_q [$];
    logic [`EE_DATA_W-1:0] ref_mem [0:(1 << `EE_ADDR_W) - 1];
    int                    errors = 0;
    int                    passed = 0;
    int                    done_count = 0;
    int                    cycles = 0;
    int                    limit = 0;

    assign sda_line = !(dut_pull || model_pull);   // open drain

    eeprom_master i_dut (
        .CLK          (CLK),
        .RESET        (RESET),
        .wr           (wr),
        .rd           (rd),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .done         (done),
        .busy         (busy),
        .scl          (scl),
        .sda_pull_low (dut_pull),
        .sda_in       (sda_line)
    );

    eeprom_model i_model (
        .CLK          (CLK),
        .scl          (scl),
        .sda          (sda_line),
        .sda_pull_low (model_pull)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (done)
            done_count <= done_count + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("Timeout: no done after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic load_tests();
        int                    fd;
        int                    c;
        byte                   kind;
        logic [`EE_ADDR_W-1:0] a;
        logic [`EE_DATA_W-1:0] d;
        fd = $fopen("sim/eeprom_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test data file");
            errors++;
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1)
        begin
            if (kind == "#")
            begin
                c = $fgetc(fd);
                while (c != 10 && c != -1)   // up to newline or end of file
                    c = $fgetc(fd);
            end
            else if ($fscanf(fd, "%h %h", a, d) == 2)
            begin
                op_q.push_back(kind);
                addr_q.push_back(a);
                data_q.push_back(d);
            end
            else
            begin
                $display("Malformed line in the test data file");
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        bit ok;
        ok = 1;
        assert (scl && !dut_pull && !done && !busy)
        else
        begin
            $display("test reset: outputs not idle after reset");
            ok = 0;
        end
        if (ok)
            passed++;
        else
            errors++;
        $display("test reset: %s", ok ? "ok" : "failed");
    endtask

    task automatic run_op(input int idx);
        byte                   kind;
        logic [`EE_ADDR_W-1:0] a;
        logic [`EE_DATA_W-1:0] d;
        logic [`EE_DATA_W-1:0] exp;
        int                    dones_before;
        bit                    ok;
        string                 name;
        kind = op_q[idx];
        a    = addr_q[idx];
        d    = data_q[idx];
        name = $sformatf("%0d %c %03h", idx, kind, a);
        ok   = 1;
        dones_before = done_count;

        @(posedge CLK);
        addr  <= a;
        wdata <= d;
        wr    <= (kind == "W");
        rd    <= (kind != "W");
        @(posedge CLK);
        rd <= 1'b0;
        wr <= (kind == "B");   // write request held through the read
        @(negedge CLK);
        assert (busy)
        else
        begin
            $display("test %s: busy did not rise after the request", name);
            ok = 0;
        end

        while (!done)
            @(negedge CLK);

        if (kind == "W")
            ref_mem[a] = d;
        else
        begin
            exp = (kind == "R") ? d : ref_mem[a];
            assert (rdata == exp)
            else
            begin
                $display("Mismatch test %s expected %02h actual %02h", name, exp, rdata);
                ok = 0;
            end
        end

        @(posedge CLK);
        wr <= 1'b0;
        repeat (3) @(negedge CLK);
        assert (!busy && done_count - dones_before == 1)
        else
        begin
            $display("test %s: extra transaction or missing done", name);
            ok = 0;
        end
        if (ok)
            passed++;
        else
            errors++;
        $display("test %s: %s", name, ok ? "ok" : "failed");
    endtask

    initial
    begin
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            ref_mem[i] = 8'hff;
        load_tests();
        limit = op_q.size() * (39 * 4 * `EE_QUARTER + 20) + 40;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_reset_state();
        for (int i = 0; i < op_q.size(); i++)
            run_op(i);
        $display("tests passed %0d failed %0d", passed, errors);
        if (errors == 0 && op_q.size() > 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim/eeprom_testdata.txt
# columns: op (W write, R read, B read with wr held) address data
# for R the data column is the expected byte, for B the held write data
W 005 a5
R 005 a5
W 105 3c
W 205 c3
R 005 a5
R 105 3c
R 205 c3
R 7ff ff
W 105 77
R 105 77
B 205 00
R 205 c3

// File: tb.f
+incdir+logic
logic/eeprom_pkg.sv
logic/eeprom_sequencer.sv
logic/scl_bit_timer.sv
logic/sda_shifter.sv
logic/eeprom_master.sv
sim/eeprom_model.sv
sim/eeprom_properties.sv
sim/eeprom_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module eeprom_master_tb -o sim_tb --Mdir obj_dir

output=$(./obj_dir/sim_tb || true)
echo "$output"

if grep -q "^TESTBENCH PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi
